// File: Bender.yml
package:
  name: rv_id

sources:
  - include_dirs:
      - .
    files:
      - rv_id_pkg.sv
      - rv_id_decoder.sv
      - rv_id_regfile.sv
      - rv_id_pipe_ctrl.sv
      - rv_id_ex_reg.sv
      - rv_id_stage.sv
  - target: test
    include_dirs:
      - .
    files:
      - rv_id_scoreboard.sv
      - rv_id_stage_chk.sv
      - tb_rv_id_stage.sv

// File: rv_id.f
+incdir+.
rv_id_pkg.sv
rv_id_decoder.sv
rv_id_regfile.sv
rv_id_pipe_ctrl.sv
rv_id_ex_reg.sv
rv_id_stage.sv
rv_id_scoreboard.sv
rv_id_stage_chk.sv
tb_rv_id_stage.sv

// File: rv_id_config.svh
`ifndef RV_ID_CONFIG_SVH
`define RV_ID_CONFIG_SVH

// ==============================
// Decode stage configuration
// ==============================

// Data path width, RV32I only
`define RV_ID_XLEN 32

// Architectural register count, x0 included
`define RV_ID_NUM_REGS 32

// Register number width
`define RV_ID_REG_ADDR_W 5

`endif

// File: rv_id_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module rv_id_decoder (
  input  rv_id_pkg::instr_t      instr_i,
  output logic                   reg_write_o,
  output logic                   mem_read_o,
  output logic                   mem_write_o,
  output logic                   alu_b_src_o,
  output logic                   is_branch_o,
  output logic                   is_jal_o,
  output logic                   is_jalr_o,
  output logic                   trap_o,
  output logic                   rs1_used_o,
  output logic                   rs2_used_o,
  output rv_id_pkg::alu_a_src_e  alu_a_src_o,
  output rv_id_pkg::res_src_e    res_src_o,
  output rv_id_pkg::reg_addr_t   rd_o,
  output rv_id_pkg::reg_addr_t   rs1_o,
  output rv_id_pkg::reg_addr_t   rs2_o,
  output rv_id_pkg::funct3_t     funct3_o,
  output rv_id_pkg::funct7_t     funct7_o,
  output rv_id_pkg::word_t       imm_o
);

  rv_id_pkg::opcode_e opcode;
  rv_id_pkg::word_t   imm_itype;
  rv_id_pkg::word_t   imm_stype;
  rv_id_pkg::word_t   imm_btype;
  rv_id_pkg::word_t   imm_utype;
  rv_id_pkg::word_t   imm_jtype;

  assign opcode = rv_id_pkg::opcode_e'(instr_i[6:0]);

  // Register and function fields sit at fixed positions in every format
  assign rd_o     = instr_i[11:7];
  assign rs1_o    = instr_i[19:15];
  assign rs2_o    = instr_i[24:20];
  assign funct3_o = instr_i[14:12];
  assign funct7_o = instr_i[31:25];

  // ==============================
  // Immediate formats
  // ==============================
  assign imm_itype = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_stype = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_btype = {{19{instr_i[31]}}, instr_i[31], instr_i[7],
                      instr_i[30:25], instr_i[11:8], 1'b0};
  assign imm_utype = {instr_i[31:12], 12'h000};
  assign imm_jtype = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12],
                      instr_i[20], instr_i[30:21], 1'b0};

  // ==============================
  // Control decode
  // ==============================
  always_comb begin
    reg_write_o = 1'b0;
    mem_read_o  = 1'b0;
    mem_write_o = 1'b0;
    alu_b_src_o = 1'b0;
    is_branch_o = 1'b0;
    is_jal_o    = 1'b0;
    is_jalr_o   = 1'b0;
    trap_o      = 1'b0;
    rs1_used_o  = 1'b0;
    rs2_used_o  = 1'b0;
    alu_a_src_o = rv_id_pkg::RS1;
    res_src_o   = rv_id_pkg::ALU;
    imm_o       = '0;

    case (opcode)
      rv_id_pkg::OP: begin
        reg_write_o = 1'b1;
        rs1_used_o  = 1'b1;
        rs2_used_o  = 1'b1;
      end
      rv_id_pkg::OP_IMM: begin
        reg_write_o = 1'b1;
        rs1_used_o  = 1'b1;
        alu_b_src_o = 1'b1;
        imm_o       = imm_itype;
      end
      rv_id_pkg::LOAD: begin
        reg_write_o = 1'b1;
        mem_read_o  = 1'b1;
        rs1_used_o  = 1'b1;
        alu_b_src_o = 1'b1;
        res_src_o   = rv_id_pkg::MEM;
        imm_o       = imm_itype;
      end
      rv_id_pkg::STORE: begin
        mem_write_o = 1'b1;
        rs1_used_o  = 1'b1;
        rs2_used_o  = 1'b1;
        alu_b_src_o = 1'b1;
        imm_o       = imm_stype;
      end
      rv_id_pkg::BRANCH: begin
        // ALU forms the target, the compare reads both sources
        is_branch_o = 1'b1;
        rs1_used_o  = 1'b1;
        rs2_used_o  = 1'b1;
        alu_a_src_o = rv_id_pkg::PC;
        alu_b_src_o = 1'b1;
        imm_o       = imm_btype;
      end
      rv_id_pkg::JAL: begin
        reg_write_o = 1'b1;
        is_jal_o    = 1'b1;
        alu_a_src_o = rv_id_pkg::PC;
        alu_b_src_o = 1'b1;
        res_src_o   = rv_id_pkg::PC4;
        imm_o       = imm_jtype;
      end
      rv_id_pkg::JALR: begin
        reg_write_o = 1'b1;
        is_jalr_o   = 1'b1;
        rs1_used_o  = 1'b1;
        alu_b_src_o = 1'b1;
        res_src_o   = rv_id_pkg::PC4;
        imm_o       = imm_itype;
      end
      rv_id_pkg::LUI: begin
        reg_write_o = 1'b1;
        alu_a_src_o = rv_id_pkg::ZERO;
        alu_b_src_o = 1'b1;
        imm_o       = imm_utype;
      end
      rv_id_pkg::AUIPC: begin
        reg_write_o = 1'b1;
        alu_a_src_o = rv_id_pkg::PC;
        alu_b_src_o = 1'b1;
        imm_o       = imm_utype;
      end
      default: begin
        // unknown opcode, all side effects stay off
        trap_o = 1'b1;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: rv_id_ex_reg.sv
`timescale 1ns/1ps
`default_nettype none

module rv_id_ex_reg (
  input  logic                  clk,
  input  logic                  load_i,
  input  logic                  reg_write_i,
  input  logic                  mem_read_i,
  input  logic                  mem_write_i,
  input  rv_id_pkg::alu_a_src_e alu_a_src_i,
  input  logic                  alu_b_src_i,
  input  rv_id_pkg::res_src_e   res_src_i,
  input  logic                  is_branch_i,
  input  logic                  is_jal_i,
  input  logic                  is_jalr_i,
  input  logic                  trap_i,
  input  rv_id_pkg::reg_addr_t  rd_i,
  input  rv_id_pkg::funct3_t    funct3_i,
  input  rv_id_pkg::funct7_t    funct7_i,
  input  rv_id_pkg::word_t      imm_i,
  input  rv_id_pkg::word_t      rs1_data_i,
  input  rv_id_pkg::word_t      rs2_data_i,
  input  rv_id_pkg::word_t      pc_i,
  output logic                  reg_write_o,
  output logic                  mem_read_o,
  output logic                  mem_write_o,
  output rv_id_pkg::alu_a_src_e alu_a_src_o,
  output logic                  alu_b_src_o,
  output rv_id_pkg::res_src_e   res_src_o,
  output logic                  is_branch_o,
  output logic                  is_jal_o,
  output logic                  is_jalr_o,
  output logic                  trap_o,
  output rv_id_pkg::reg_addr_t  rd_o,
  output rv_id_pkg::funct3_t    funct3_o,
  output rv_id_pkg::funct7_t    funct7_o,
  output rv_id_pkg::word_t      imm_o,
  output rv_id_pkg::word_t      rs1_data_o,
  output rv_id_pkg::word_t      rs2_data_o,
  output rv_id_pkg::word_t      pc_o
);

  // Contents of an empty slot are don't care, the valid bit lives in pipe control
  always_ff @(posedge clk) begin
    if (load_i) begin
      reg_write_o <= reg_write_i;
      mem_read_o  <= mem_read_i;
      mem_write_o <= mem_write_i;
      alu_a_src_o <= alu_a_src_i;
      alu_b_src_o <= alu_b_src_i;
      res_src_o   <= res_src_i;
      is_branch_o <= is_branch_i;
      is_jal_o    <= is_jal_i;
      is_jalr_o   <= is_jalr_i;
      trap_o      <= trap_i;
      rd_o        <= rd_i;
      funct3_o    <= funct3_i;
      funct7_o    <= funct7_i;
      imm_o       <= imm_i;
      rs1_data_o  <= rs1_data_i;
      rs2_data_o  <= rs2_data_i;
      pc_o        <= pc_i;
    end
  end

endmodule

`default_nettype wire

// File: rv_id_pipe_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module rv_id_pipe_ctrl (
  input  logic clk,
  input  logic reset_i,
  input  logic s_valid_i,
  input  logic m_ready_i,
  input  logic hazard_i,
  input  logic flush_i,
  output logic s_ready_o,
  output logic m_valid_o,
  output logic load_o
);

  // Slot can take a new entry when empty or draining, never on a hazard
  assign s_ready_o = (!m_valid_o || m_ready_i) && !hazard_i;
  assign load_o    = s_ready_o;

  // ==============================
  // ID/EX valid bit
  // ==============================
  always_ff @(posedge clk) begin
    if (reset_i) begin
      m_valid_o <= 1'b0;
    end else if (s_ready_o) begin
      m_valid_o <= s_valid_i && !flush_i;
    end else begin
      // Held under back-pressure, bubble once EX takes it during a hazard
      m_valid_o <= m_valid_o && !m_ready_i && !flush_i;
    end
  end

endmodule

`default_nettype wire

// File: rv_id_pkg.sv
`default_nettype none

`include "rv_id_config.svh"

package rv_id_pkg;

  // Plain vector types
  typedef logic [`RV_ID_XLEN-1:0]       word_t;
  typedef logic [31:0]                  instr_t;
  typedef logic [`RV_ID_REG_ADDR_W-1:0] reg_addr_t;
  typedef logic [2:0]                   funct3_t;
  typedef logic [6:0]                   funct7_t;

  // RV32I base opcodes handled by the decoder
  typedef enum logic [6:0] {
    OP     = 7'b0110011,
    OP_IMM = 7'b0010011,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011,
    BRANCH = 7'b1100011,
    JAL    = 7'b1101111,
    JALR   = 7'b1100111,
    LUI    = 7'b0110111,
    AUIPC  = 7'b0010111
  } opcode_e;

  // ALU operand A select
  typedef enum logic [1:0] {
    RS1  = 2'd0,
    PC   = 2'd1,
    ZERO = 2'd2
  } alu_a_src_e;

  // Result select in writeback
  typedef enum logic [1:0] {
    ALU = 2'd0,
    MEM = 2'd1,
    PC4 = 2'd2
  } res_src_e;

endpackage

`default_nettype wire

// File: rv_id_regfile.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_id_config.svh"

module rv_id_regfile (
  input  logic                 clk,
  input  rv_id_pkg::reg_addr_t rs1_addr_i,
  input  rv_id_pkg::reg_addr_t rs2_addr_i,
  output rv_id_pkg::word_t     rs1_data_o,
  output rv_id_pkg::word_t     rs2_data_o,
  input  logic                 wb_en_i,
  input  rv_id_pkg::reg_addr_t wb_addr_i,
  input  rv_id_pkg::word_t     wb_data_i
);

  // No storage behind x0
  rv_id_pkg::word_t regs [1:`RV_ID_NUM_REGS-1];

  always_ff @(posedge clk) begin
    if (wb_en_i && (wb_addr_i != '0)) begin
      regs[wb_addr_i] <= wb_data_i;
    end
  end

  // Read port with writeback bypass
  function automatic rv_id_pkg::word_t read_port(input rv_id_pkg::reg_addr_t addr);
    rv_id_pkg::word_t data;
    if (addr == '0) begin
      data = '0;
    end else if (wb_en_i && (wb_addr_i == addr)) begin
      data = wb_data_i;
    end else begin
      data = regs[addr];
    end
    return data;
  endfunction

  always_comb begin
    rs1_data_o = read_port(rs1_addr_i);
    rs2_data_o = read_port(rs2_addr_i);
  end

endmodule

`default_nettype wire

// File: rv_id_scoreboard.sv
`timescale 1ns/1ps
`default_nettype none

module rv_id_scoreboard (
  input  logic                  clk,
  input  logic                  reset_i,
  input  logic                  s_valid_i,
  input  logic                  s_ready_i,
  input  rv_id_pkg::instr_t     instr_i,
  input  rv_id_pkg::word_t      pc_i,
  input  logic                  flush_i,
  input  logic                  hazard_i,
  input  rv_id_pkg::word_t      model_rs1_i,
  input  rv_id_pkg::word_t      model_rs2_i,
  input  rv_id_pkg::reg_addr_t  rs1_id_i,
  input  rv_id_pkg::reg_addr_t  rs2_id_i,
  input  logic                  rs1_used_i,
  input  logic                  rs2_used_i,
  input  logic                  m_valid_i,
  input  logic                  m_ready_i,
  input  logic                  ex_reg_write_i,
  input  logic                  ex_mem_read_i,
  input  logic                  ex_mem_write_i,
  input  rv_id_pkg::alu_a_src_e ex_alu_a_src_i,
  input  logic                  ex_alu_b_src_i,
  input  rv_id_pkg::res_src_e   ex_res_src_i,
  input  logic                  ex_is_branch_i,
  input  logic                  ex_is_jal_i,
  input  logic                  ex_is_jalr_i,
  input  logic                  ex_trap_i,
  input  rv_id_pkg::reg_addr_t  ex_rd_i,
  input  rv_id_pkg::funct3_t    ex_funct3_i,
  input  rv_id_pkg::funct7_t    ex_funct7_i,
  input  rv_id_pkg::word_t      ex_imm_i,
  input  rv_id_pkg::word_t      ex_rs1_data_i,
  input  rv_id_pkg::word_t      ex_rs2_data_i,
  input  rv_id_pkg::word_t      ex_pc_i,
  output int unsigned           error_cnt_o,
  output int unsigned           check_cnt_o,
  output int unsigned           drop_cnt_o,
  output int unsigned           pending_o
);

  typedef struct packed {
    logic                 reg_write;
    logic                 mem_read;
    logic                 mem_write;
    logic [1:0]           alu_a_src;
    logic                 alu_b_src;
    logic [1:0]           res_src;
    logic                 is_branch;
    logic                 is_jal;
    logic                 is_jalr;
    logic                 trap;
    logic                 rs1_used;
    logic                 rs2_used;
    rv_id_pkg::reg_addr_t rd;
    rv_id_pkg::funct3_t   funct3;
    rv_id_pkg::funct7_t   funct7;
    rv_id_pkg::word_t     imm;
    rv_id_pkg::word_t     rs1_data;
    rv_id_pkg::word_t     rs2_data;
    rv_id_pkg::word_t     pc;
  } bundle_t;

  bundle_t     exp_q [$];
  bundle_t     now_exp;
  bundle_t     head;
  int unsigned error_cnt = 0;
  int unsigned check_cnt = 0;
  int unsigned drop_cnt = 0;
  int unsigned pending = 0;

  assign error_cnt_o = error_cnt;
  assign check_cnt_o = check_cnt;
  assign drop_cnt_o  = drop_cnt;
  assign pending_o   = pending;

  // ==============================
  // Reference RV32I decode
  // ==============================
  function automatic bundle_t ref_decode(input rv_id_pkg::instr_t instr,
                                         input rv_id_pkg::word_t pc,
                                         input rv_id_pkg::word_t rs1_val,
                                         input rv_id_pkg::word_t rs2_val);
    bundle_t          b;
    rv_id_pkg::word_t imm_i;
    rv_id_pkg::word_t imm_s;
    rv_id_pkg::word_t imm_b;
    rv_id_pkg::word_t imm_u;
    rv_id_pkg::word_t imm_j;
    imm_i = {{20{instr[31]}}, instr[31:20]};
    imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    imm_u = {instr[31:12], 12'b0};
    imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
    b = '0;
    b.rd       = instr[11:7];
    b.funct3   = instr[14:12];
    b.funct7   = instr[31:25];
    b.rs1_data = rs1_val;
    b.rs2_data = rs2_val;
    b.pc       = pc;
    b.alu_a_src = rv_id_pkg::RS1;
    b.res_src   = rv_id_pkg::ALU;
    case (instr[6:0])
      7'b0110011: begin
        b.reg_write = 1'b1;
        b.rs1_used  = 1'b1;
        b.rs2_used  = 1'b1;
      end
      7'b0010011: begin
        b.reg_write = 1'b1;
        b.rs1_used  = 1'b1;
        b.alu_b_src = 1'b1;
        b.imm       = imm_i;
      end
      7'b0000011: begin
        b.reg_write = 1'b1;
        b.mem_read  = 1'b1;
        b.rs1_used  = 1'b1;
        b.alu_b_src = 1'b1;
        b.res_src   = rv_id_pkg::MEM;
        b.imm       = imm_i;
      end
      7'b0100011: begin
        b.mem_write = 1'b1;
        b.rs1_used  = 1'b1;
        b.rs2_used  = 1'b1;
        b.alu_b_src = 1'b1;
        b.imm       = imm_s;
      end
      7'b1100011: begin
        b.is_branch = 1'b1;
        b.rs1_used  = 1'b1;
        b.rs2_used  = 1'b1;
        b.alu_a_src = rv_id_pkg::PC;
        b.alu_b_src = 1'b1;
        b.imm       = imm_b;
      end
      7'b1101111: begin
        b.reg_write = 1'b1;
        b.is_jal    = 1'b1;
        b.alu_a_src = rv_id_pkg::PC;
        b.alu_b_src = 1'b1;
        b.res_src   = rv_id_pkg::PC4;
        b.imm       = imm_j;
      end
      7'b1100111: begin
        b.reg_write = 1'b1;
        b.is_jalr   = 1'b1;
        b.rs1_used  = 1'b1;
        b.alu_b_src = 1'b1;
        b.res_src   = rv_id_pkg::PC4;
        b.imm       = imm_i;
      end
      7'b0110111: begin
        b.reg_write = 1'b1;
        b.alu_a_src = rv_id_pkg::ZERO;
        b.alu_b_src = 1'b1;
        b.imm       = imm_u;
      end
      7'b0010111: begin
        b.reg_write = 1'b1;
        b.alu_a_src = rv_id_pkg::PC;
        b.alu_b_src = 1'b1;
        b.imm       = imm_u;
      end
      default: begin
        b.trap = 1'b1;
      end
    endcase
    return b;
  endfunction

  task automatic check_field(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAILED %s: got %h, expected %h", name, got, exp);
      error_cnt++;
    end
  endtask

  task automatic compare_bundle(input bundle_t e);
    check_field("reg_write_o", ex_reg_write_i, e.reg_write);
    check_field("mem_read_o", ex_mem_read_i, e.mem_read);
    check_field("mem_write_o", ex_mem_write_i, e.mem_write);
    check_field("alu_a_src_o", ex_alu_a_src_i, e.alu_a_src);
    check_field("alu_b_src_o", ex_alu_b_src_i, e.alu_b_src);
    check_field("res_src_o", ex_res_src_i, e.res_src);
    check_field("is_branch_o", ex_is_branch_i, e.is_branch);
    check_field("is_jal_o", ex_is_jal_i, e.is_jal);
    check_field("is_jalr_o", ex_is_jalr_i, e.is_jalr);
    check_field("trap_o", ex_trap_i, e.trap);
    check_field("rd_o", ex_rd_i, e.rd);
    check_field("funct3_o", ex_funct3_i, e.funct3);
    check_field("funct7_o", ex_funct7_i, e.funct7);
    check_field("imm_o", ex_imm_i, e.imm);
    check_field("rs1_data_o", ex_rs1_data_i, e.rs1_data);
    check_field("rs2_data_o", ex_rs2_data_i, e.rs2_data);
    check_field("pc_o", ex_pc_i, e.pc);
  endtask

  // ==============================
  // Edge sampling
  // ==============================
  always @(posedge clk) begin
    if (!reset_i) begin
      now_exp = ref_decode(instr_i, pc_i, model_rs1_i, model_rs2_i);

      // Hazard unit outputs follow instr_i combinationally
      check_field("rs1_id_o", rs1_id_i, instr_i[19:15]);
      check_field("rs2_id_o", rs2_id_i, instr_i[24:20]);
      check_field("rs1_used_o", rs1_used_i, now_exp.rs1_used);
      check_field("rs2_used_o", rs2_used_i, now_exp.rs2_used);

      // Slot is occupied exactly when an entry is outstanding
      check_field("m_valid_o", m_valid_i, exp_q.size() != 0);
      check_field("s_ready_o", s_ready_i,
                  ((exp_q.size() == 0) || m_ready_i) && !hazard_i);

      // Old entry leaves before a new one is taken at the same edge
      if (m_valid_i && m_ready_i) begin
        if (exp_q.size() == 0) begin
          $display("ERROR: bundle handed to EX with nothing outstanding");
          error_cnt++;
        end else begin
          head = exp_q.pop_front();
          compare_bundle(head);
          check_cnt++;
        end
      end else if (m_valid_i && flush_i && (exp_q.size() != 0)) begin
        // Flushed while stalled in the slot
        head = exp_q.pop_front();
        drop_cnt++;
      end

      if (s_valid_i && s_ready_i) begin
        if (flush_i) begin
          drop_cnt++;
        end else begin
          exp_q.push_back(now_exp);
        end
      end
      pending = exp_q.size();
    end
  end

endmodule

`default_nettype wire

// File: rv_id_stage.sv
`timescale 1ns/1ps
`default_nettype none

module rv_id_stage (
  input  logic                  clk,
  input  logic                  reset_i,
  // IF side
  input  logic                  s_valid_i,
  input  rv_id_pkg::instr_t     instr_i,
  input  rv_id_pkg::word_t      pc_i,
  output logic                  s_ready_o,
  // Hazard unit and redirect
  input  logic                  hazard_i,
  input  logic                  flush_i,
  output rv_id_pkg::reg_addr_t  rs1_id_o,
  output rv_id_pkg::reg_addr_t  rs2_id_o,
  output logic                  rs1_used_o,
  output logic                  rs2_used_o,
  // Writeback
  input  logic                  wb_en_i,
  input  rv_id_pkg::reg_addr_t  wb_addr_i,
  input  rv_id_pkg::word_t      wb_data_i,
  // EX side
  output logic                  m_valid_o,
  input  logic                  m_ready_i,
  output logic                  reg_write_o,
  output logic                  mem_read_o,
  output logic                  mem_write_o,
  output rv_id_pkg::alu_a_src_e alu_a_src_o,
  output logic                  alu_b_src_o,
  output rv_id_pkg::res_src_e   res_src_o,
  output logic                  is_branch_o,
  output logic                  is_jal_o,
  output logic                  is_jalr_o,
  output logic                  trap_o,
  output rv_id_pkg::reg_addr_t  rd_o,
  output rv_id_pkg::funct3_t    funct3_o,
  output rv_id_pkg::funct7_t    funct7_o,
  output rv_id_pkg::word_t      imm_o,
  output rv_id_pkg::word_t      rs1_data_o,
  output rv_id_pkg::word_t      rs2_data_o,
  output rv_id_pkg::word_t      pc_o
);

  // Decode side of the stage
  logic                  reg_write_d;
  logic                  mem_read_d;
  logic                  mem_write_d;
  rv_id_pkg::alu_a_src_e alu_a_src_d;
  logic                  alu_b_src_d;
  rv_id_pkg::res_src_e   res_src_d;
  logic                  is_branch_d;
  logic                  is_jal_d;
  logic                  is_jalr_d;
  logic                  trap_d;
  rv_id_pkg::reg_addr_t  rd_d;
  rv_id_pkg::funct3_t    funct3_d;
  rv_id_pkg::funct7_t    funct7_d;
  rv_id_pkg::word_t      imm_d;
  rv_id_pkg::word_t      rs1_data_d;
  rv_id_pkg::word_t      rs2_data_d;
  logic                  load;

  rv_id_decoder rv_id_decoder_inst (
    .instr_i     (instr_i),
    .reg_write_o (reg_write_d),
    .mem_read_o  (mem_read_d),
    .mem_write_o (mem_write_d),
    .alu_b_src_o (alu_b_src_d),
    .is_branch_o (is_branch_d),
    .is_jal_o    (is_jal_d),
    .is_jalr_o   (is_jalr_d),
    .trap_o      (trap_d),
    .rs1_used_o  (rs1_used_o),
    .rs2_used_o  (rs2_used_o),
    .alu_a_src_o (alu_a_src_d),
    .res_src_o   (res_src_d),
    .rd_o        (rd_d),
    .rs1_o       (rs1_id_o),
    .rs2_o       (rs2_id_o),
    .funct3_o    (funct3_d),
    .funct7_o    (funct7_d),
    .imm_o       (imm_d)
  );

  rv_id_regfile rv_id_regfile_inst (
    .clk        (clk),
    .rs1_addr_i (rs1_id_o),
    .rs2_addr_i (rs2_id_o),
    .rs1_data_o (rs1_data_d),
    .rs2_data_o (rs2_data_d),
    .wb_en_i    (wb_en_i),
    .wb_addr_i  (wb_addr_i),
    .wb_data_i  (wb_data_i)
  );

  // ==============================
  // ID/EX slot
  // ==============================
  rv_id_pipe_ctrl rv_id_pipe_ctrl_inst (
    .clk       (clk),
    .reset_i   (reset_i),
    .s_valid_i (s_valid_i),
    .m_ready_i (m_ready_i),
    .hazard_i  (hazard_i),
    .flush_i   (flush_i),
    .s_ready_o (s_ready_o),
    .m_valid_o (m_valid_o),
    .load_o    (load)
  );

  rv_id_ex_reg rv_id_ex_reg_inst (
    .clk         (clk),
    .load_i      (load),
    .reg_write_i (reg_write_d),
    .mem_read_i  (mem_read_d),
    .mem_write_i (mem_write_d),
    .alu_a_src_i (alu_a_src_d),
    .alu_b_src_i (alu_b_src_d),
    .res_src_i   (res_src_d),
    .is_branch_i (is_branch_d),
    .is_jal_i    (is_jal_d),
    .is_jalr_i   (is_jalr_d),
    .trap_i      (trap_d),
    .rd_i        (rd_d),
    .funct3_i    (funct3_d),
    .funct7_i    (funct7_d),
    .imm_i       (imm_d),
    .rs1_data_i  (rs1_data_d),
    .rs2_data_i  (rs2_data_d),
    .pc_i        (pc_i),
    .reg_write_o (reg_write_o),
    .mem_read_o  (mem_read_o),
    .mem_write_o (mem_write_o),
    .alu_a_src_o (alu_a_src_o),
    .alu_b_src_o (alu_b_src_o),
    .res_src_o   (res_src_o),
    .is_branch_o (is_branch_o),
    .is_jal_o    (is_jal_o),
    .is_jalr_o   (is_jalr_o),
    .trap_o      (trap_o),
    .rd_o        (rd_o),
    .funct3_o    (funct3_o),
    .funct7_o    (funct7_o),
    .imm_o       (imm_o),
    .rs1_data_o  (rs1_data_o),
    .rs2_data_o  (rs2_data_o),
    .pc_o        (pc_o)
  );

endmodule

`default_nettype wire

// File: rv_id_stage_chk.sv
`timescale 1ns/1ps
`default_nettype none

module rv_id_stage_chk (
  input logic                 clk,
  input logic                 reset_i,
  input logic                 s_ready_i,
  input logic                 m_valid_i,
  input logic                 m_ready_i,
  input logic                 hazard_i,
  input logic                 flush_i,
  input rv_id_pkg::word_t     ex_pc_i,
  input rv_id_pkg::reg_addr_t ex_rd_i
);

  int unsigned hold_fail = 0;
  int unsigned hazard_fail = 0;
  int unsigned reset_fail = 0;
  int unsigned fail_cnt;

  assign fail_cnt = hold_fail + hazard_fail + reset_fail;

  // ==============================
  // Handshake properties
  // ==============================

  // A stalled bundle stays put unless it is flushed
  hold_a: assert property (@(posedge clk) disable iff (reset_i)
    m_valid_i && !m_ready_i && !flush_i |=> m_valid_i && $stable(ex_pc_i) && $stable(ex_rd_i))
    else begin
      $error("ID/EX bundle changed while EX was stalling");
      hold_fail++;
    end

  hazard_a: assert property (@(posedge clk) disable iff (reset_i)
    hazard_i |-> !s_ready_i)
    else begin
      $error("stage accepted an instruction during a hazard");
      hazard_fail++;
    end

  reset_a: assert property (@(posedge clk) reset_i |=> !m_valid_i)
    else begin
      $error("m_valid_o set right after reset");
      reset_fail++;
    end

endmodule

bind rv_id_stage rv_id_stage_chk rv_id_stage_chk_inst (
  .clk       (clk),
  .reset_i   (reset_i),
  .s_ready_i (s_ready_o),
  .m_valid_i (m_valid_o),
  .m_ready_i (m_ready_i),
  .hazard_i  (hazard_i),
  .flush_i   (flush_i),
  .ex_pc_i   (pc_o),
  .ex_rd_i   (rd_o)
);

`default_nettype wire

// File: tb_rv_id_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_id_config.svh"

module tb_rv_id_stage;

  localparam int NUM_INSTR      = 200;
  localparam int TIMEOUT_CYCLES = NUM_INSTR * 20;
  localparam int RESET_CYCLES   = 5;

  logic                  clk;
  logic                  reset_i;
  logic                  s_valid_i;
  rv_id_pkg::instr_t     instr_i;
  rv_id_pkg::word_t      pc_i;
  logic                  s_ready_o;
  logic                  hazard_i;
  logic                  flush_i;
  rv_id_pkg::reg_addr_t  rs1_id_o;
  rv_id_pkg::reg_addr_t  rs2_id_o;
  logic                  rs1_used_o;
  logic                  rs2_used_o;
  logic                  wb_en_i;
  rv_id_pkg::reg_addr_t  wb_addr_i;
  rv_id_pkg::word_t      wb_data_i;
  logic                  m_valid_o;
  logic                  m_ready_i;
  logic                  reg_write_o;
  logic                  mem_read_o;
  logic                  mem_write_o;
  rv_id_pkg::alu_a_src_e alu_a_src_o;
  logic                  alu_b_src_o;
  rv_id_pkg::res_src_e   res_src_o;
  logic                  is_branch_o;
  logic                  is_jal_o;
  logic                  is_jalr_o;
  logic                  trap_o;
  rv_id_pkg::reg_addr_t  rd_o;
  rv_id_pkg::funct3_t    funct3_o;
  rv_id_pkg::funct7_t    funct7_o;
  rv_id_pkg::word_t      imm_o;
  rv_id_pkg::word_t      rs1_data_o;
  rv_id_pkg::word_t      rs2_data_o;
  rv_id_pkg::word_t      pc_o;

  // Register model and the operand values it predicts for instr_i
  rv_id_pkg::word_t reg_model [0:`RV_ID_NUM_REGS-1];
  rv_id_pkg::word_t model_rs1;
  rv_id_pkg::word_t model_rs2;

  int unsigned sb_errors;
  int unsigned sb_checked;
  int unsigned sb_dropped;
  int unsigned sb_pending;
  int unsigned total_errors;
  int unsigned seed;
  int unsigned sent;
  int unsigned cycle_cnt;
  logic        holding;
  logic        fired;

  rv_id_stage rv_id_stage_inst (.*);

  rv_id_scoreboard rv_id_scoreboard_inst (
    .clk             (clk),
    .reset_i         (reset_i),
    .s_valid_i       (s_valid_i),
    .s_ready_i       (s_ready_o),
    .instr_i         (instr_i),
    .pc_i            (pc_i),
    .flush_i         (flush_i),
    .hazard_i        (hazard_i),
    .model_rs1_i     (model_rs1),
    .model_rs2_i     (model_rs2),
    .rs1_id_i        (rs1_id_o),
    .rs2_id_i        (rs2_id_o),
    .rs1_used_i      (rs1_used_o),
    .rs2_used_i      (rs2_used_o),
    .m_valid_i       (m_valid_o),
    .m_ready_i       (m_ready_i),
    .ex_reg_write_i  (reg_write_o),
    .ex_mem_read_i   (mem_read_o),
    .ex_mem_write_i  (mem_write_o),
    .ex_alu_a_src_i  (alu_a_src_o),
    .ex_alu_b_src_i  (alu_b_src_o),
    .ex_res_src_i    (res_src_o),
    .ex_is_branch_i  (is_branch_o),
    .ex_is_jal_i     (is_jal_o),
    .ex_is_jalr_i    (is_jalr_o),
    .ex_trap_i       (trap_o),
    .ex_rd_i         (rd_o),
    .ex_funct3_i     (funct3_o),
    .ex_funct7_i     (funct7_o),
    .ex_imm_i        (imm_o),
    .ex_rs1_data_i   (rs1_data_o),
    .ex_rs2_data_i   (rs2_data_o),
    .ex_pc_i         (pc_o),
    .error_cnt_o     (sb_errors),
    .check_cnt_o     (sb_checked),
    .drop_cnt_o      (sb_dropped),
    .pending_o       (sb_pending)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // ==============================
  // Helpers
  // ==============================

  // Register file view including a same-cycle writeback
  function automatic rv_id_pkg::word_t model_read(input rv_id_pkg::reg_addr_t addr);
    rv_id_pkg::word_t data;
    if (addr == '0) begin
      data = '0;
    end else if (wb_en_i && (wb_addr_i == addr)) begin
      data = wb_data_i;
    end else begin
      data = reg_model[addr];
    end
    return data;
  endfunction

  // Random fields with an opcode from the RV32I set or an unsupported one
  function automatic rv_id_pkg::instr_t random_instr();
    rv_id_pkg::instr_t instr;
    instr = $urandom;
    case ($urandom_range(11, 0))
      0:       instr[6:0] = 7'b0110011;
      1:       instr[6:0] = 7'b0010011;
      2:       instr[6:0] = 7'b0000011;
      3:       instr[6:0] = 7'b0100011;
      4:       instr[6:0] = 7'b1100011;
      5:       instr[6:0] = 7'b1101111;
      6:       instr[6:0] = 7'b1100111;
      7:       instr[6:0] = 7'b0110111;
      8:       instr[6:0] = 7'b0010111;
      9:       instr[6:0] = 7'b1110011;
      10:      instr[6:0] = 7'b0001111;
      default: instr[6:0] = 7'b1111111;
    endcase
    return instr;
  endfunction

  // Advances one clock and reports an upstream transfer and applies the writeback
  task automatic step_cycle(output logic accepted);
    @(posedge clk);
    accepted = s_valid_i && s_ready_o;
    if (wb_en_i && (wb_addr_i != '0)) begin
      reg_model[wb_addr_i] = wb_data_i;
    end
    @(negedge clk);
  endtask

  // ==============================
  // Stimulus
  // ==============================
  initial begin
    seed = 61;
    void'($urandom(seed));
    reset_i   = 1'b1;
    s_valid_i = 1'b0;
    instr_i   = '0;
    pc_i      = 32'h0000_1000;
    hazard_i  = 1'b0;
    flush_i   = 1'b0;
    m_ready_i = 1'b0;
    wb_en_i   = 1'b0;
    wb_addr_i = '0;
    wb_data_i = '0;
    model_rs1 = '0;
    model_rs2 = '0;
    holding   = 1'b0;
    sent      = 0;
    for (int r = 0; r < `RV_ID_NUM_REGS; r++) begin
      reg_model[r] = '0;
    end
    repeat (RESET_CYCLES) @(negedge clk);
    reset_i = 1'b0;

    // Give every register a known value first
    for (int r = 1; r < `RV_ID_NUM_REGS; r++) begin
      wb_en_i   = 1'b1;
      wb_addr_i = r;
      wb_data_i = $urandom;
      step_cycle(fired);
    end

    while (sent < NUM_INSTR) begin
      if (!holding && ($urandom_range(9, 0) != 0)) begin
        instr_i = random_instr();
        pc_i    = pc_i + 32'd4;
        holding = 1'b1;
      end
      s_valid_i = holding;
      hazard_i  = ($urandom_range(99, 0) < 15);
      m_ready_i = ($urandom_range(99, 0) < 60);
      flush_i   = m_ready_i && ($urandom_range(99, 0) < 4);
      wb_en_i   = ($urandom_range(99, 0) < 80);
      wb_addr_i = $urandom;
      wb_data_i = $urandom;
      model_rs1 = model_read(instr_i[19:15]);
      model_rs2 = model_read(instr_i[24:20]);
      step_cycle(fired);
      if (fired) begin
        holding = 1'b0;
        sent++;
      end
    end

    // Drain the slot
    s_valid_i = 1'b0;
    hazard_i  = 1'b0;
    flush_i   = 1'b0;
    m_ready_i = 1'b1;
    wb_en_i   = 1'b0;
    while ((sb_pending != 0) || m_valid_o) begin
      step_cycle(fired);
    end

    total_errors = sb_errors + rv_id_stage_inst.rv_id_stage_chk_inst.fail_cnt;
    $display("Summary: sent %0d, checked %0d, dropped %0d, errors %0d, assertion errors %0d",
             sent, sb_checked, sb_dropped, total_errors,
             rv_id_stage_inst.rv_id_stage_chk_inst.fail_cnt);
    if (total_errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  // Watchdog
  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("ERROR: run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("*** FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire
